// File: cfu_pkg.sv
`default_nettype none

package cfu_pkg;

  //////////////////////////////////////////////////
  // command encoding
  //////////////////////////////////////////////////

  // function id is funct7 over funct3
  localparam int FUNCTION_ID_WIDTH = 10;
  localparam int FUNCT3_WIDTH      = 3;
  localparam int FUNCT7_WIDTH      = 7;

  // operand and result width
  localparam int XLEN = 32;
  typedef logic [XLEN-1:0] xlen_t;

  // funct3 opcodes that are decoded, anything else answers zero
  localparam logic [FUNCT3_WIDTH-1:0] OP_BYTE_ADD    = 3'd0;
  localparam logic [FUNCT3_WIDTH-1:0] OP_INSTR_WRITE = 3'd3;
  localparam logic [FUNCT3_WIDTH-1:0] OP_INSTR_READ  = 3'd4;
  localparam logic [FUNCT3_WIDTH-1:0] OP_BANK_WRITE  = 3'd5;
  localparam logic [FUNCT3_WIDTH-1:0] OP_BANK_READ   = 3'd6;

  // returned for every write
  localparam xlen_t ACK_WORD = '1;

  //////////////////////////////////////////////////
  // instruction memory
  //////////////////////////////////////////////////
  localparam int INSTR_AWIDTH = 9;
  localparam int INSTR_DEPTH  = 512;
  typedef logic [31:0] instr_word_t;

  //////////////////////////////////////////////////
  // data banks
  //////////////////////////////////////////////////

  // 32 bit word plus one extra byte per row
  localparam int BANK_WORD_WIDTH = 40;
  localparam int BANK_BYTE_WIDTH = 8;
  typedef logic [BANK_WORD_WIDTH-1:0] bank_word_t;

  localparam int BANK_ROW_AWIDTH = 9;
  localparam int BANK_DEPTH      = 512;
  localparam int NUM_BANKS       = 4;
  localparam int BANK_SEL_WIDTH  = 2;
  // bank select sits above the row bits
  typedef logic [BANK_SEL_WIDTH+BANK_ROW_AWIDTH-1:0] bank_addr_t;

  // write address lives in operand 1, above the data byte
  localparam int BANK_WR_ADDR_LSB = 8;

endpackage

`default_nettype wire

// File: word_ram.sv
`timescale 1ns/100ps
`default_nettype none

// single port memory, one word per address
// write and read share the address, read data is registered
module word_ram #(
  parameter type word_t = logic [31:0],
  parameter int DEPTH = 512,
  localparam int AWIDTH = $clog2(DEPTH)
) (
  input  logic              clk,
  input  logic [AWIDTH-1:0] addr,
  input  logic              wr_en,
  input  word_t             wr_data,
  output word_t             rd_data
);

  // storage
  word_t mem [DEPTH];

  // write on strobe
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr] <= wr_data;
    end
  end

  // read every cycle, one cycle latency
  // old contents come out when reading the address being written
  always_ff @(posedge clk) begin
    rd_data <= mem[addr];
  end

endmodule

`default_nettype wire

// File: data_bank_array.sv
`timescale 1ns/100ps
`default_nettype none

module data_bank_array (
  input  logic                                clk,
  input  logic                                resetn,
  input  cfu_pkg::bank_addr_t                 addr,
  input  logic                                wr_en,
  input  cfu_pkg::xlen_t                      wr_word,
  input  logic [cfu_pkg::BANK_BYTE_WIDTH-1:0] wr_byte,
  output cfu_pkg::xlen_t                      rd_word,
  output logic [cfu_pkg::BANK_BYTE_WIDTH-1:0] rd_byte
);

  import cfu_pkg::*;

  // address split
  logic [BANK_SEL_WIDTH-1:0]  sel;
  logic [BANK_ROW_AWIDTH-1:0] row;
  // bank select delayed to match the memory read
  logic [BANK_SEL_WIDTH-1:0]  sel_q;

  bank_word_t packed_word;
  bank_word_t bank_rd [NUM_BANKS];
  bank_word_t picked_word;
  bank_word_t unpacked_word;

  assign sel = addr[BANK_ROW_AWIDTH +: BANK_SEL_WIDTH];
  assign row = addr[BANK_ROW_AWIDTH-1:0];

  //////////////////////////////////////////////////
  // write packing
  //////////////////////////////////////////////////

  // word goes bit reversed into the upper 32 bits,
  // byte goes bit reversed into the lower 8
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      packed_word[BANK_BYTE_WIDTH+i] = wr_word[XLEN-1-i];
    end
    for (int i = 0; i < BANK_BYTE_WIDTH; i++) begin
      packed_word[i] = wr_byte[BANK_BYTE_WIDTH-1-i];
    end
  end

  //////////////////////////////////////////////////
  // banks
  //////////////////////////////////////////////////

  // all banks see the same row and data, only the
  // selected one gets the write strobe
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    word_ram #(
      .word_t (bank_word_t),
      .DEPTH  (BANK_DEPTH)
    ) u_bank (
      .clk     (clk),
      .addr    (row),
      .wr_en   (wr_en && (sel == BANK_SEL_WIDTH'(b))),
      .wr_data (packed_word),
      .rd_data (bank_rd[b])
    );
  end

  //////////////////////////////////////////////////
  // read unpacking
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel;
    end
  end

  assign picked_word = bank_rd[sel_q];

  // full 40 bit reversal undoes the packing
  always_comb begin
    for (int i = 0; i < BANK_WORD_WIDTH; i++) begin
      unpacked_word[i] = picked_word[BANK_WORD_WIDTH-1-i];
    end
  end

  // low part is the original word, top byte the original byte
  assign rd_word = unpacked_word[XLEN-1:0];
  assign rd_byte = unpacked_word[BANK_WORD_WIDTH-1 -: BANK_BYTE_WIDTH];

endmodule

`default_nettype wire

// File: cmd_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_sequencer (
  input  logic                                  clk,
  input  logic                                  resetn,
  // command channel
  input  logic                                  cmd_valid,
  output logic                                  cmd_ready,
  input  logic [cfu_pkg::FUNCTION_ID_WIDTH-1:0] cmd_function_id,
  input  cfu_pkg::xlen_t                        cmd_input_0,
  input  cfu_pkg::xlen_t                        cmd_input_1,
  // response channel
  output logic                                  rsp_valid,
  input  logic                                  rsp_ready,
  output cfu_pkg::xlen_t                        rsp_output,
  // instruction memory
  output logic [cfu_pkg::INSTR_AWIDTH-1:0]      instr_addr,
  output logic                                  instr_wr_en,
  output cfu_pkg::instr_word_t                  instr_wr_data,
  input  cfu_pkg::instr_word_t                  instr_rd_data,
  // data banks
  output cfu_pkg::bank_addr_t                   bank_addr,
  output logic                                  bank_wr_en,
  output cfu_pkg::xlen_t                        bank_wr_word,
  output logic [cfu_pkg::BANK_BYTE_WIDTH-1:0]   bank_wr_byte,
  input  cfu_pkg::xlen_t                        bank_rd_word,
  input  logic [cfu_pkg::BANK_BYTE_WIDTH-1:0]   bank_rd_byte
);

  import cfu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_FETCH,
    ST_RESPOND
  } state_t;

  state_t state;

  // captured command
  logic [FUNCT3_WIDTH-1:0] funct3_q;
  logic [FUNCT7_WIDTH-1:0] funct7_q;
  xlen_t                   op0_q;
  xlen_t                   op1_q;

  logic                    cmd_fire;
  logic                    rsp_fire;
  logic                    is_read;
  logic [BANK_BYTE_WIDTH:0] byte_sum;
  xlen_t                   result;

  assign cmd_fire = cmd_valid && cmd_ready;
  assign rsp_fire = rsp_valid && rsp_ready;

  // reads need one more cycle for the memory output
  assign is_read = (funct3_q == OP_INSTR_READ) || (funct3_q == OP_BANK_READ);

  //////////////////////////////////////////////////
  // control FSM
  //////////////////////////////////////////////////

  // idle    -> wait for a command
  // issue   -> addresses and strobes go out
  // fetch   -> memory busy reading
  // respond -> load result, then hold until taken
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state       <= ST_IDLE;
      cmd_ready   <= 1'b1;
      rsp_valid   <= 1'b0;
      instr_wr_en <= 1'b0;
      bank_wr_en  <= 1'b0;
    end else begin
      // write strobes are single cycle pulses
      instr_wr_en <= 1'b0;
      bank_wr_en  <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (cmd_fire) begin
            cmd_ready <= 1'b0;
            state     <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          instr_wr_en <= (funct3_q == OP_INSTR_WRITE);
          bank_wr_en  <= (funct3_q == OP_BANK_WRITE);
          state       <= is_read ? ST_FETCH : ST_RESPOND;
        end
        ST_FETCH: begin
          state <= ST_RESPOND;
        end
        ST_RESPOND: begin
          // first cycle raises valid, then wait for the taker
          if (!rsp_valid) begin
            rsp_valid <= 1'b1;
          end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
            cmd_ready <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // datapath registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // capture operands and split the function id
    if (state == ST_IDLE && cmd_fire) begin
      funct3_q <= cmd_function_id[FUNCT3_WIDTH-1:0];
      funct7_q <= cmd_function_id[FUNCTION_ID_WIDTH-1:FUNCT3_WIDTH];
      op0_q    <= cmd_input_0;
      op1_q    <= cmd_input_1;
    end
    // memory side, addresses come from the captured operands
    if (state == ST_ISSUE) begin
      instr_addr    <= op0_q[INSTR_AWIDTH-1:0];
      instr_wr_data <= op1_q;
      bank_wr_word  <= op0_q;
      bank_wr_byte  <= op1_q[BANK_BYTE_WIDTH-1:0];
      // writes take the address from operand 1, reads from operand 0
      if (funct3_q == OP_BANK_WRITE) begin
        bank_addr <= op1_q[BANK_WR_ADDR_LSB +: $bits(bank_addr_t)];
      end else begin
        bank_addr <= op0_q[$bits(bank_addr_t)-1:0];
      end
    end
    // result is loaded once and held while valid is up
    if (state == ST_RESPOND && !rsp_valid) begin
      rsp_output <= result;
    end
  end

  //////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////

  // nine bit sum keeps the carry
  assign byte_sum = op0_q[BANK_BYTE_WIDTH-1:0] + op1_q[BANK_BYTE_WIDTH-1:0];

  always_comb begin
    result = '0;
    case (funct3_q)
      OP_BYTE_ADD: begin
        result = XLEN'(byte_sum);
      end
      OP_INSTR_WRITE, OP_BANK_WRITE: begin
        result = ACK_WORD;
      end
      OP_INSTR_READ: begin
        result = instr_rd_data;
      end
      OP_BANK_READ: begin
        // funct7 picks the word part or the byte part
        if (funct7_q == FUNCT7_WIDTH'(0)) begin
          result = bank_rd_word;
        end else if (funct7_q == FUNCT7_WIDTH'(1)) begin
          result = XLEN'(bank_rd_byte);
        end
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: cfu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cfu_top (
  input  logic                                  clk,
  input  logic                                  resetn,
  // command channel
  input  logic                                  cmd_valid,
  output logic                                  cmd_ready,
  input  logic [cfu_pkg::FUNCTION_ID_WIDTH-1:0] cmd_function_id,
  input  cfu_pkg::xlen_t                        cmd_input_0,
  input  cfu_pkg::xlen_t                        cmd_input_1,
  // response channel
  output logic                                  rsp_valid,
  input  logic                                  rsp_ready,
  output cfu_pkg::xlen_t                        rsp_output
);

  import cfu_pkg::*;

  // sequencer to instruction memory
  logic [INSTR_AWIDTH-1:0]    instr_addr;
  logic                       instr_wr_en;
  instr_word_t                instr_wr_data;
  instr_word_t                instr_rd_data;

  // sequencer to bank array
  bank_addr_t                 bank_addr;
  logic                       bank_wr_en;
  xlen_t                      bank_wr_word;
  logic [BANK_BYTE_WIDTH-1:0] bank_wr_byte;
  xlen_t                      bank_rd_word;
  logic [BANK_BYTE_WIDTH-1:0] bank_rd_byte;

  //////////////////////////////////////////////////
  // command handling
  //////////////////////////////////////////////////
  cmd_sequencer u_seq (
    .clk             (clk),
    .resetn          (resetn),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_input_0     (cmd_input_0),
    .cmd_input_1     (cmd_input_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_output      (rsp_output),
    .instr_addr      (instr_addr),
    .instr_wr_en     (instr_wr_en),
    .instr_wr_data   (instr_wr_data),
    .instr_rd_data   (instr_rd_data),
    .bank_addr       (bank_addr),
    .bank_wr_en      (bank_wr_en),
    .bank_wr_word    (bank_wr_word),
    .bank_wr_byte    (bank_wr_byte),
    .bank_rd_word    (bank_rd_word),
    .bank_rd_byte    (bank_rd_byte)
  );

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // instruction memory, plain 32 bit words
  word_ram #(
    .word_t (instr_word_t),
    .DEPTH  (INSTR_DEPTH)
  ) u_instr_mem (
    .clk     (clk),
    .addr    (instr_addr),
    .wr_en   (instr_wr_en),
    .wr_data (instr_wr_data),
    .rd_data (instr_rd_data)
  );

  // four 40 bit data banks
  data_bank_array u_banks (
    .clk     (clk),
    .resetn  (resetn),
    .addr    (bank_addr),
    .wr_en   (bank_wr_en),
    .wr_word (bank_wr_word),
    .wr_byte (bank_wr_byte),
    .rd_word (bank_rd_word),
    .rd_byte (bank_rd_byte)
  );

endmodule

`default_nettype wire

// File: tb_cfu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cfu;

  import cfu_pkg::*;

  localparam int          CLK_PERIOD     = 8;
  localparam int          RESET_CYCLES   = 10;
  localparam int          CYCLES_PER_VEC = 12;
  localparam int          NAME_CHARS     = 24;
  localparam string       VECTOR_FILE    = "tb_cfu_input.txt";
  localparam logic [31:0] SEED           = 32'h5f25_7a63;

  logic                         clk;
  logic                         resetn;
  logic                         cmd_valid;
  logic                         cmd_ready;
  logic [FUNCTION_ID_WIDTH-1:0] cmd_function_id;
  xlen_t                        cmd_input_0;
  xlen_t                        cmd_input_1;
  logic                         rsp_valid;
  logic                         rsp_ready;
  xlen_t                        rsp_output;

  // one entry per vector line
  logic [8*NAME_CHARS-1:0] vec_name [$];
  logic [FUNCT3_WIDTH-1:0] vec_funct3 [$];
  logic [FUNCT7_WIDTH-1:0] vec_funct7 [$];
  xlen_t                   vec_op0 [$];
  xlen_t                   vec_op1 [$];
  xlen_t                   vec_expected [$];

  logic vectors_loaded;

  //////////////////////////////////////////////////
  // clock and DUT
  //////////////////////////////////////////////////
  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  cfu_top u_dut (
    .clk             (clk),
    .resetn          (resetn),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_input_0     (cmd_input_0),
    .cmd_input_1     (cmd_input_1),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_output      (rsp_output)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string test_name, input string what,
                             input xlen_t expected, input xlen_t actual);
    assert (actual === expected) else begin
      fail_run($sformatf("[ERROR] %s %s expected %h actual %h",
                         test_name, what, expected, actual));
    end
  endtask

  // scanned names are right aligned with zero bytes in front
  function automatic string name_text(input logic [8*NAME_CHARS-1:0] packed_name);
    string text;
    text = "";
    for (int i = NAME_CHARS-1; i >= 0; i--) begin
      if (packed_name[8*i +: 8] != 8'h00) begin
        text = $sformatf("%s%c", text, packed_name[8*i +: 8]);
      end
    end
    return text;
  endfunction

  // lines starting with # are comments
  task automatic load_vectors();
    int                      fd;
    int                      fields;
    string                   line;
    logic [8*NAME_CHARS-1:0] name;
    logic [FUNCT3_WIDTH-1:0] f3;
    logic [FUNCT7_WIDTH-1:0] f7;
    xlen_t                   op0;
    xlen_t                   op1;
    xlen_t                   expected;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      fail_run("could not open the vector file tb_cfu_input.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%s %h %h %h %h %h", name, f3, f7, op0, op1, expected);
      if (fields != 6) begin
        fail_run($sformatf("malformed line in the vector file: %s", line));
      end
      vec_name.push_back(name);
      vec_funct3.push_back(f3);
      vec_funct7.push_back(f7);
      vec_op0.push_back(op0);
      vec_op1.push_back(op1);
      vec_expected.push_back(expected);
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // one command is entered and left on a falling edge
  //////////////////////////////////////////////////
  task automatic run_command(input int idx);
    string test_name;
    int    expected_edges;
    int    edges;
    int    hold_cycles;
    xlen_t held_value;
    test_name = name_text(vec_name[idx]);
    // reads pay one more cycle for the memory
    expected_edges = ((vec_funct3[idx] == OP_INSTR_READ) ||
                      (vec_funct3[idx] == OP_BANK_READ)) ? 3 : 2;
    hold_cycles = int'($urandom % 4);

    cmd_function_id = {vec_funct7[idx], vec_funct3[idx]};
    cmd_input_0     = vec_op0[idx];
    cmd_input_1     = vec_op1[idx];
    cmd_valid       = 1'b1;
    // the next rising edge with cmd_ready high takes the command
    while (!cmd_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    // junk on the idle bus must not leak in
    cmd_valid       = 1'b0;
    cmd_function_id = FUNCTION_ID_WIDTH'($urandom);
    cmd_input_0     = $urandom;
    cmd_input_1     = $urandom;

    // each falling edge stands for one rising edge passed
    edges = 0;
    while (!rsp_valid) begin
      assert (!cmd_ready) else begin
        fail_run($sformatf("cmd_ready rose before the response in test %s", test_name));
      end
      @(negedge clk);
      edges++;
    end
    check_value(test_name, "latency", expected_edges, edges);

    // response must hold under back-pressure
    held_value = rsp_output;
    assert (!cmd_ready) else begin
      fail_run($sformatf("cmd_ready high with a pending response in test %s", test_name));
    end
    repeat (hold_cycles) begin
      @(negedge clk);
      assert (rsp_valid) else begin
        fail_run($sformatf("rsp_valid dropped before it was taken in test %s", test_name));
      end
      assert (!cmd_ready) else begin
        fail_run($sformatf("cmd_ready high with a pending response in test %s", test_name));
      end
      check_value(test_name, "held rsp_output", held_value, rsp_output);
    end
    check_value(test_name, "result", vec_expected[idx], rsp_output);

    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    assert (!rsp_valid) else begin
      fail_run($sformatf("rsp_valid still high after it was taken in test %s", test_name));
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    resetn          = 1'b0;
    cmd_valid       = 1'b0;
    cmd_function_id = '0;
    cmd_input_0     = '0;
    cmd_input_1     = '0;
    rsp_ready       = 1'b0;
    vectors_loaded  = 1'b0;
    void'($urandom(SEED));

    load_vectors();
    vectors_loaded = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
    assert (!rsp_valid) else begin
      fail_run("rsp_valid is high right after reset");
    end
    assert (cmd_ready) else begin
      fail_run("cmd_ready is low right after reset");
    end

    for (int i = 0; i < vec_name.size(); i++) begin
      run_command(i);
    end
    $display("%0d commands checked", vec_name.size());
    $display("Simulation completed successfully");
    $finish;
  end

  // watchdog budget scales with the vector count
  initial begin
    int limit_cycles;
    wait (vectors_loaded);
    limit_cycles = vec_name.size() * CYCLES_PER_VEC + RESET_CYCLES;
    repeat (limit_cycles) @(posedge clk);
    fail_run($sformatf("watchdog expired after %0d cycles, the DUT stopped answering",
                       limit_cycles));
  end

endmodule

`default_nettype wire

// File: tb_cfu_input.txt
# columns: test name, funct3, funct7, operand 0, operand 1, expected result
# all numeric columns are hex
add_basic          0 00 00000012 00000034 00000046
add_carry          0 00 000000ff 000000ff 000001fe
add_high_bytes     0 00 deadbe01 12345680 00000081
add_zero           0 00 00000000 00000000 00000000
imem_wr_0          3 00 00000000 cafef00d ffffffff
imem_wr_1ff        3 00 000001ff 12345678 ffffffff
imem_wr_55         3 00 00000055 a5a55a5a ffffffff
imem_rd_0          4 00 00000000 00000000 cafef00d
imem_rd_1ff        4 00 000001ff 00000000 12345678
imem_rd_55         4 00 00000055 00000000 a5a55a5a
imem_wr_0_again    3 00 00000000 0badc0de ffffffff
imem_rd_0_again    4 00 00000000 00000000 0badc0de
imem_rd_55_hi      4 00 fffffe55 00000000 a5a55a5a
bank0_wr           5 00 11112222 00002311 ffffffff
bank1_wr           5 00 33334444 00022322 ffffffff
bank2_wr           5 00 55556666 00042333 ffffffff
bank3_wr           5 00 77778888 00062344 ffffffff
bank0_rd_word      6 00 00000023 00000000 11112222
bank0_rd_byte      6 01 00000023 00000000 00000011
bank1_rd_word      6 00 00000223 00000000 33334444
bank1_rd_byte      6 01 00000223 00000000 00000022
bank2_rd_word      6 00 00000423 00000000 55556666
bank2_rd_byte      6 01 00000423 00000000 00000033
bank3_rd_word      6 00 00000623 00000000 77778888
bank3_rd_byte      6 01 00000623 00000000 00000044
bank2_wr_edge      5 00 80000001 0005ffc3 ffffffff
bank2_rd_edge_word 6 00 000005ff 00000000 80000001
bank2_rd_edge_byte 6 01 000005ff 00000000 000000c3
bank0_rd_funct7_2  6 02 00000023 00000000 00000000
unused_f3_1        1 00 ffffffff ffffffff 00000000
unused_f3_2        2 7f 12345678 9abcdef0 00000000
unused_f3_7        7 00 0000007f 00000001 00000000

// File: all.f
cfu_pkg.sv
word_ram.sv
data_bank_array.sv
cmd_sequencer.sv
cfu_top.sv
tb_cfu.sv

// File: Makefile
VERILATOR    ?= verilator
FILELIST     := all.f
TOP          := tb_cfu
RTL_TOP      := cfu_top
BUILD_DIR    := obj_dir
COMMON_FLAGS := --timing --assert
LINT_FLAGS   := --lint-only $(COMMON_FLAGS)
SIM_FLAGS    := --binary $(COMMON_FLAGS) -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
